//--- build.f
source/rv_pkg.sv
source/id_stage.sv
source/reg_file.sv
source/id_ex.sv
source/ex.sv
source/retire_reg.sv
source/core_top.sv
dv/tb_core.sv

//--- Makefile
TOP       ?= tb_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import rv_pkg::*;

    localparam int num_inst   = 600;
    localparam int max_cycles = num_inst + 200; // reset and drain margin

    logic        clk_i;
    logic        arst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic [31:0] inst_addr_i;
    retire_t     retire_o;

    logic [31:0] model_regs [32];
    retire_t     exp_q [$];
    int          errors;
    int          checks;
    int          cycles;

    core_top core_top_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .retire_o     (retire_o)
    );

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    function automatic logic [4:0] pick_reg();
        if ($urandom_range(0, 7) == 0) begin
            return 5'($urandom_range(0, 31));
        end
        return 5'($urandom_range(0, 7)); // mostly x0..x7 so results chain
    endfunction

    function automatic logic [31:0] gen_inst();
        logic [31:0] w;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        int          kind;
        kind = $urandom_range(0, 15);
        f3   = 3'($urandom_range(0, 7));
        w    = $urandom;
        boff = 13'($urandom_range(0, 255)) << 1;
        joff = 21'($urandom_range(0, 1023)) << 1;
        if ($urandom_range(0, 1) == 1) begin
            boff = -boff;
            joff = -joff;
        end
        case (kind)
            0, 1, 2, 3: begin
                imm = 12'($urandom);
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm[11:5] = (f3 == 3'b101 && $urandom_range(0, 1) == 1) ? 7'b0100000 : 7'b0;
                    case ($urandom_range(0, 3))
                        0:       imm[4:0] = 5'd0;
                        1:       imm[4:0] = 5'd31;
                        default: imm[4:0] = 5'($urandom);
                    endcase
                end
                w = {imm, pick_reg(), f3, pick_reg(), op_imm};
            end
            4, 5, 6: begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1) ?
                     7'b0100000 : 7'b0;
                w  = {f7, pick_reg(), pick_reg(), f3, pick_reg(), op_reg};
            end
            7, 8: begin
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    f3 = 3'b000; // no branch at these codes
                end
                w = {boff[12], boff[10:5], pick_reg(), pick_reg(), f3, boff[4:1], boff[11],
                     op_branch};
            end
            9:  w = {joff[20], joff[10:1], joff[11], joff[19:12], pick_reg(), op_jal};
            10: w = {12'($urandom), pick_reg(), 3'b000, pick_reg(), op_jalr};
            11: w = {w[31:12], pick_reg(), op_lui};
            12: w = {w[31:12], pick_reg(), op_auipc};
            13, 14: begin
                case ($urandom_range(0, 5))
                    0:       w[6:0] = 7'b0000011; // load
                    1:       w[6:0] = 7'b0100011; // store
                    2:       w[6:0] = 7'b0001111; // fence
                    3:       w[6:0] = 7'b1110011; // system
                    4:       w[6:0] = 7'b1111111;
                    default: w[6:0] = 7'b0000000;
                endcase
            end
            default: w = {12'($urandom), pick_reg(), 3'b000, pick_reg(), op_imm};
        endcase
        return w;
    endfunction

    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic [31:0] a,
                                               input logic [31:0] b, input logic sub,
                                               input logic arith);
        logic [4:0]  sh;
        logic [31:0] sra;
        sh  = b[4:0];
        sra = $signed(a) >>> sh;
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return arith ? sra : a >> sh;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // in-order ISA model that runs one instruction per call
    task automatic model_exec(input logic [31:0] w, input logic [31:0] pc, output retire_t rec);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_u;
        logic [31:0] res;
        logic        wen;
        logic [4:0]  rd;
        rec   = '0;
        rec.valid = 1'b1;
        rec.pc    = pc;
        rd    = w[11:7];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        imm_u = {w[31:12], 12'b0};
        wen   = 1'b1;
        res   = '0;
        case (w[6:0])
            op_imm: res = alu_result(w[14:12], a, imm_i, 1'b0, w[30]);
            op_reg: res = alu_result(w[14:12], a, b, w[30], w[30]);
            op_branch: begin
                wen = 1'b0;
                if (branch_taken(w[14:12], a, b)) begin
                    rec.jump = '{en: 1'b1, addr: pc + imm_b};
                end
            end
            op_jal: begin
                res      = pc + 32'd4;
                rec.jump = '{en: 1'b1, addr: pc + imm_j};
            end
            op_jalr: begin
                res      = pc + 32'd4;
                rec.jump = '{en: 1'b1, addr: a + imm_i}; // rs1 read before the link write
            end
            op_lui:   res = imm_u;
            op_auipc: res = pc + imm_u;
            default:  wen = 1'b0;
        endcase
        rec.wb = '{wen: wen, waddr: wen ? rd : 5'd0, wdata: res};
        if (wen && rd != 5'd0) begin
            model_regs[rd] = res;
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0d ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_retire(input retire_t exp);
        compare_field("retire_o.valid", 32'(retire_o.valid), 32'(exp.valid));
        compare_field("retire_o.wb.wen", 32'(retire_o.wb.wen), 32'(exp.wb.wen));
        compare_field("retire_o.jump.en", 32'(retire_o.jump.en), 32'(exp.jump.en));
        if (exp.valid) begin
            compare_field("retire_o.pc", retire_o.pc, exp.pc);
            compare_field("retire_o.jump.addr", retire_o.jump.addr, exp.jump.addr);
        end
        if (exp.wb.wen) begin
            compare_field("retire_o.wb.waddr", 32'(retire_o.wb.waddr), 32'(exp.wb.waddr));
            compare_field("retire_o.wb.wdata", retire_o.wb.wdata, exp.wb.wdata);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        retire_t     rec;
        logic [31:0] pc;
        logic [31:0] target;
        logic [31:0] word;
        logic        squash_now;
        logic        squash_next;
        logic        issue;
        void'($urandom(32'h289a_c557));
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        inst_addr_i  = '0;
        errors       = 0;
        checks       = 0;
        pc           = 32'h0000_1000;
        target       = '0;
        squash_next  = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        exp_q.push_back('0); // reset state shows on the first two checks
        exp_q.push_back('0);
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        for (int cyc = 0; cyc < num_inst + 2; cyc++) begin
            check_retire(exp_q.pop_front());
            issue        = (cyc < num_inst) && ($urandom_range(0, 7) != 0);
            word         = gen_inst();
            inst_valid_i = issue;
            inst_i       = word;
            inst_addr_i  = pc;
            squash_now   = squash_next;
            squash_next  = 1'b0;
            rec          = '0;
            if (squash_now) begin
                pc = target; // wrong-path slot while fetch redirects
            end else if (issue) begin
                model_exec(word, pc, rec);
                squash_next = rec.jump.en;
                target      = rec.jump.addr;
                pc          = pc + 32'd4;
            end
            exp_q.push_back(rec);
            @(negedge clk_i);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire logic        inst_valid_i,
    input  wire logic [31:0] inst_i,
    input  wire logic [31:0] inst_addr_i,
    output rv_pkg::retire_t  retire_o
);
    import rv_pkg::*;

    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    id_ex_t      id_ex_d;
    id_ex_t      id_ex_q;
    wb_t         wb;
    jump_t       jump;

    id_stage id_stage_inst (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .id_ex_o      (id_ex_d)
    );

    reg_file reg_file_inst (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb)
    );

    id_ex id_ex_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .id_ex_i  (id_ex_d),
        .jump_i   (jump),
        .id_ex_o  (id_ex_q)
    );

    ex ex_inst (
        .id_ex_i (id_ex_q),
        .wb_o    (wb),
        .jump_o  (jump)
    );

    retire_reg retire_reg_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (id_ex_q.valid),
        .pc_i     (id_ex_q.inst_addr),
        .wb_i     (wb),
        .jump_i   (jump),
        .retire_o (retire_o)
    );

endmodule

`default_nettype wire

//--- source/retire_reg.sv
`timescale 1ns/1ps
`default_nettype none

module retire_reg (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire logic        valid_i,
    input  wire logic [31:0] pc_i,
    input  rv_pkg::wb_t      wb_i,
    input  rv_pkg::jump_t    jump_i,
    output rv_pkg::retire_t  retire_o
);

    logic        valid_q;
    logic        wen_q;
    logic        jump_en_q;
    logic [31:0] pc_q;
    logic [4:0]  waddr_q;
    logic [31:0] wdata_q;
    logic [31:0] jump_addr_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q   <= 1'b0;
            wen_q     <= 1'b0;
            jump_en_q <= 1'b0;
        end else begin
            valid_q   <= valid_i;
            wen_q     <= wb_i.wen;
            jump_en_q <= valid_i && jump_i.en;
        end
    end

    always_ff @(posedge clk_i) begin
        pc_q        <= pc_i;
        waddr_q     <= wb_i.waddr;
        wdata_q     <= wb_i.wdata;
        jump_addr_q <= jump_i.en ? jump_i.addr : '0; // target only when taken
    end

    assign retire_o.valid     = valid_q;
    assign retire_o.pc        = pc_q;
    assign retire_o.wb.wen    = wen_q;
    assign retire_o.wb.waddr  = waddr_q;
    assign retire_o.wb.wdata  = wdata_q;
    assign retire_o.jump.en   = jump_en_q;
    assign retire_o.jump.addr = jump_addr_q;

    a_wen_needs_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        retire_o.wb.wen |-> retire_o.valid);

endmodule

`default_nettype wire

//--- source/ex.sv
`timescale 1ns/1ps
`default_nettype none

module ex (
    input  rv_pkg::id_ex_t id_ex_i,
    output rv_pkg::wb_t    wb_o,
    output rv_pkg::jump_t  jump_o
);
    import rv_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  func3;
    logic        func7_b5;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [4:0]  shamt;
    logic [31:0] imm_b;
    logic        eq;
    logic        lt_s;
    logic        lt_u;
    logic [31:0] sra_res;
    logic [31:0] alu_res;
    logic        br_taken;

    assign opcode   = id_ex_i.inst.r_view.opcode;
    assign func3    = id_ex_i.inst.r_view.func3;
    assign func7_b5 = id_ex_i.inst.r_view.func7[5]; // also bit 30 of the srai imm
    assign op1      = id_ex_i.op1;
    assign op2      = id_ex_i.op2;
    assign shamt    = op2[4:0];

    assign imm_b = {{20{id_ex_i.inst.b_view.imm_12}}, id_ex_i.inst.b_view.imm_11,
                    id_ex_i.inst.b_view.imm_10_5, id_ex_i.inst.b_view.imm_4_1, 1'b0};

    assign eq   = (op1 == op2);
    assign lt_s = ($signed(op1) < $signed(op2));
    assign lt_u = (op1 < op2);

    assign sra_res = $signed(op1) >>> shamt;

    always_comb begin
        case (func3)
            f3_add_sub: alu_res = (opcode == op_reg && func7_b5) ? op1 - op2 : op1 + op2;
            f3_sll:     alu_res = op1 << shamt;
            f3_slt:     alu_res = {31'b0, lt_s};
            f3_sltu:    alu_res = {31'b0, lt_u};
            f3_xor:     alu_res = op1 ^ op2;
            f3_sr:      alu_res = func7_b5 ? sra_res : op1 >> shamt;
            f3_or:      alu_res = op1 | op2;
            default:    alu_res = op1 & op2; // f3_and
        endcase
    end

    always_comb begin
        case (func3)
            f3_beq:  br_taken = eq;
            f3_bne:  br_taken = !eq;
            f3_blt:  br_taken = lt_s;
            f3_bge:  br_taken = !lt_s;
            f3_bltu: br_taken = lt_u;
            f3_bgeu: br_taken = !lt_u;
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        wb_o   = '0;
        jump_o = '0;
        if (id_ex_i.valid) begin
            wb_o.wen   = id_ex_i.reg_wen;
            wb_o.waddr = id_ex_i.rd_addr;
            case (opcode)
                op_imm, op_reg: wb_o.wdata = alu_res;
                op_branch: begin
                    jump_o.en   = br_taken;
                    jump_o.addr = br_taken ? id_ex_i.inst_addr + imm_b : '0;
                end
                op_jal: begin
                    wb_o.wdata  = id_ex_i.inst_addr + 32'd4; // link
                    jump_o.en   = 1'b1;
                    jump_o.addr = id_ex_i.inst_addr + op2;
                end
                op_jalr: begin
                    wb_o.wdata  = id_ex_i.inst_addr + 32'd4;
                    jump_o.en   = 1'b1;
                    jump_o.addr = op1 + op2;
                end
                op_lui:   wb_o.wdata = op2;
                op_auipc: wb_o.wdata = op1 + op2;
                default: begin
                    wb_o.wen   = 1'b0; // unsupported opcode retires quietly
                    wb_o.waddr = '0;
                end
            endcase
        end
    end

    always_comb begin
        a_jump_ctrl_only: assert final (!jump_o.en || opcode == op_branch ||
                                        opcode == op_jal || opcode == op_jalr);
    end

endmodule

`default_nettype wire

//--- source/id_ex.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  rv_pkg::id_ex_t id_ex_i,
    input  rv_pkg::jump_t  jump_i,
    output rv_pkg::id_ex_t id_ex_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= '0;
        end else if (jump_i.en) begin
            id_ex_o <= '0; // squash wrong-path issue
        end else begin
            id_ex_o <= id_ex_i;
        end
    end

    a_valid_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown(id_ex_o.valid));

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire logic [4:0]  rs1_addr_i,
    input  wire logic [4:0]  rs2_addr_i,
    output logic [31:0]      rs1_data_o,
    output logic [31:0]      rs2_data_o,
    input  rv_pkg::wb_t      wb_i
);

    logic [31:0] regs [1:31]; // x0 has no storage

    function automatic logic [31:0] read_port(input logic [4:0] addr);
        logic [31:0] data;
        if (addr == 5'd0) begin
            data = '0;
        end else if (wb_i.wen && (wb_i.waddr == addr)) begin
            data = wb_i.wdata; // same-cycle bypass
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wen && (wb_i.waddr != 5'd0)) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    a_x0_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rs1_addr_i != 5'd0 || rs1_data_o == '0) && (rs2_addr_i != 5'd0 || rs2_data_o == '0));

endmodule

`default_nettype wire

//--- source/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire logic            inst_valid_i,
    input  rv_pkg::rv_inst_u     inst_i,
    input  wire logic [31:0]     inst_addr_i,
    output logic [4:0]           rs1_addr_o,
    output logic [4:0]           rs2_addr_o,
    input  wire logic [31:0]     rs1_data_i,
    input  wire logic [31:0]     rs2_data_i,
    output rv_pkg::id_ex_t       id_ex_o
);
    import rv_pkg::*;

    logic [6:0]  opcode;
    logic [31:0] imm_i;
    logic [31:0] imm_j;
    logic [31:0] imm_u;

    assign opcode     = inst_i.r_view.opcode;
    assign rs1_addr_o = inst_i.r_view.rs1;
    assign rs2_addr_o = inst_i.r_view.rs2;

    assign imm_i = {{20{inst_i.i_view.imm[11]}}, inst_i.i_view.imm};

    // J-imm bits 20|10:1|11|19:12 sit where func7, rs2, rs1, func3 are
    assign imm_j = {{12{inst_i.r_view.func7[6]}},
                    inst_i.r_view.rs1,
                    inst_i.r_view.func3,
                    inst_i.r_view.rs2[0],
                    inst_i.r_view.func7[5:0],
                    inst_i.r_view.rs2[4:1],
                    1'b0};

    assign imm_u = {inst_i.r_view.func7, inst_i.r_view.rs2, inst_i.r_view.rs1,
                    inst_i.r_view.func3, 12'b0};

    always_comb begin
        id_ex_o           = '0;
        id_ex_o.valid     = inst_valid_i;
        id_ex_o.inst      = inst_i;
        id_ex_o.inst_addr = inst_addr_i;
        id_ex_o.rd_addr   = inst_i.r_view.rd;
        case (opcode)
            op_imm: begin
                id_ex_o.op1     = rs1_data_i;
                id_ex_o.op2     = imm_i; // shamt is op2[4:0]
                id_ex_o.reg_wen = 1'b1;
            end
            op_reg: begin
                id_ex_o.op1     = rs1_data_i;
                id_ex_o.op2     = rs2_data_i;
                id_ex_o.reg_wen = 1'b1;
            end
            op_branch: begin
                id_ex_o.op1     = rs1_data_i;
                id_ex_o.op2     = rs2_data_i;
            end
            op_jal: begin
                id_ex_o.op2     = imm_j;
                id_ex_o.reg_wen = 1'b1;
            end
            op_jalr: begin
                id_ex_o.op1     = rs1_data_i;
                id_ex_o.op2     = imm_i;
                id_ex_o.reg_wen = 1'b1;
            end
            op_lui: begin
                id_ex_o.op2     = imm_u;
                id_ex_o.reg_wen = 1'b1;
            end
            op_auipc: begin
                id_ex_o.op1     = inst_addr_i;
                id_ex_o.op2     = imm_u;
                id_ex_o.reg_wen = 1'b1;
            end
            default: id_ex_o.reg_wen = 1'b0; // load, store, fence, system, illegal
        endcase
        if (!inst_valid_i) begin
            id_ex_o = '0; // bubble
        end
    end

endmodule

`default_nettype wire

//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    // shared by I-type and R-type
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_sr      = 3'b101; // srl and sra split by func7[5]
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_blt     = 3'b100;
    localparam logic [2:0] f3_bge     = 3'b101;
    localparam logic [2:0] f3_bltu    = 3'b110;
    localparam logic [2:0] f3_bgeu    = 3'b111;

    typedef union packed {
        struct packed {
            logic [6:0]  func7;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  func3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } r_view;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  func3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic        imm_12;
            logic [5:0]  imm_10_5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  func3;
            logic [3:0]  imm_4_1;
            logic        imm_11;
            logic [6:0]  opcode;
        } b_view;
    } rv_inst_u;

    typedef struct packed {
        logic        valid;
        rv_inst_u    inst;
        logic [31:0] inst_addr;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [4:0]  rd_addr;
        logic        reg_wen;
    } id_ex_t;

    typedef struct packed {
        logic        wen;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } wb_t;

    typedef struct packed {
        logic        en;
        logic [31:0] addr;
    } jump_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        wb_t         wb;
        jump_t       jump;
    } retire_t;

endpackage

`default_nettype wire
